// File: rtl/rvAlu.sv
`timescale 1ns/100ps

module rvAlu (
	input  logic [rvCorePkg::xLen-1:0]   opA,
	input  logic [rvCorePkg::xLen-1:0]   opB,
	input  logic [rvCorePkg::aluOpW-1:0] aluOp,
	input  logic [1:0]                   branchType,
	output logic [rvCorePkg::xLen-1:0]   result,
	output logic                         takeBranch
);
	import rvCorePkg::*;

	logic [4:0] shamt;
	logic       isEq;
	logic       isLt;

	assign shamt = opB[4:0];
	assign isEq = (opA == opB);
	assign isLt = ($signed(opA) < $signed(opB));

	always_comb begin
		case (aluOp)
			aluAdd:   result = opA + opB;
			aluSub:   result = opA - opB;
			aluSll:   result = opA << shamt;
			aluSlt:   result = {{(xLen-1){1'b0}}, isLt};
			aluSltu:  result = {{(xLen-1){1'b0}}, opA < opB};
			aluXor:   result = opA ^ opB;
			aluSrl:   result = opA >> shamt;
			aluSra:   result = $unsigned($signed(opA) >>> shamt);
			aluOr:    result = opA | opB;
			aluAnd:   result = opA & opB;
			aluPassB: result = opB;
			default:  result = '0;
		endcase
	end

	// {funct3[2], funct3[0]}
	always_comb begin
		case (branchType)
			2'b00:   takeBranch = isEq;
			2'b01:   takeBranch = ~isEq;
			2'b10:   takeBranch = isLt;
			default: takeBranch = ~isLt;
		endcase
	end

endmodule

// File: rtl/rvCorePkg.sv
package rvCorePkg;

	localparam int xLen     = 32;
	localparam int regAddrW = 5;
	localparam int opcodeW  = 7;
	localparam int funct3W  = 3;
	localparam int funct7W  = 7;
	localparam int aluOpW   = 4;
	localparam int wbSelW   = 2;
	localparam int sizeW    = 2;

	// major opcodes
	localparam logic [opcodeW-1:0] opLui    = 7'b0110111;
	localparam logic [opcodeW-1:0] opAuipc  = 7'b0010111;
	localparam logic [opcodeW-1:0] opJal    = 7'b1101111;
	localparam logic [opcodeW-1:0] opBranch = 7'b1100011;
	localparam logic [opcodeW-1:0] opLoad   = 7'b0000011;
	localparam logic [opcodeW-1:0] opStore  = 7'b0100011;
	localparam logic [opcodeW-1:0] opImm    = 7'b0010011;
	localparam logic [opcodeW-1:0] opReg    = 7'b0110011;
	localparam logic [opcodeW-1:0] opSystem = 7'b1110011;

	localparam logic [aluOpW-1:0] aluAdd   = 4'd0;
	localparam logic [aluOpW-1:0] aluSub   = 4'd1;
	localparam logic [aluOpW-1:0] aluSll   = 4'd2;
	localparam logic [aluOpW-1:0] aluSlt   = 4'd3;
	localparam logic [aluOpW-1:0] aluSltu  = 4'd4;
	localparam logic [aluOpW-1:0] aluXor   = 4'd5;
	localparam logic [aluOpW-1:0] aluSrl   = 4'd6;
	localparam logic [aluOpW-1:0] aluSra   = 4'd7;
	localparam logic [aluOpW-1:0] aluOr    = 4'd8;
	localparam logic [aluOpW-1:0] aluAnd   = 4'd9;
	localparam logic [aluOpW-1:0] aluPassB = 4'd10; // lui

	// writeback source select
	localparam logic [wbSelW-1:0] wbAlu     = 2'd0;
	localparam logic [wbSelW-1:0] wbMem     = 2'd1;
	localparam logic [wbSelW-1:0] wbPcPlus4 = 2'd2;
	localparam logic [wbSelW-1:0] wbPcImm   = 2'd3;

	localparam logic [sizeW-1:0] sizeByte = 2'd0;
	localparam logic [sizeW-1:0] sizeHalf = 2'd1;
	localparam logic [sizeW-1:0] sizeWord = 2'd2;

	typedef union packed {
		struct packed {
			logic [funct7W-1:0]  funct7;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [funct3W-1:0]  funct3;
			logic [regAddrW-1:0] rd;
			logic [opcodeW-1:0]  opcode;
		} rView;
		struct packed {
			logic [6:0]          immHi;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [funct3W-1:0]  funct3;
			logic [4:0]          immLo;
			logic [opcodeW-1:0]  opcode;
		} sView; // store and branch layout
	} instWordT;

endpackage

// File: rtl/rvCoreTop.sv
`timescale 1ns/100ps

module rvCoreTop (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [rvCorePkg::xLen-1:0]  inst,
	input  logic [rvCorePkg::xLen-1:0]  readData,
	output logic [rvCorePkg::xLen-1:0]  pc,
	output logic [rvCorePkg::xLen-1:0]  dataAddr,
	output logic [rvCorePkg::xLen-1:0]  storeData,
	output logic [rvCorePkg::sizeW-1:0] dataSize,
	output logic                        dataUnsigned,
	output logic                        memWrite,
	output logic                        memRead,
	output logic                        halt
);
	import rvCorePkg::*;

	instWordT          instW;
	logic [aluOpW-1:0] aluOp;
	logic              aluSrcImm;
	logic              aluSrcPc;
	logic              regWrite;
	logic [wbSelW-1:0] wbSel;
	logic              branch;
	logic [1:0]        branchType;
	logic              jump;
	logic              isEbreak;
	logic [xLen-1:0]   imm;
	logic [xLen-1:0]   rs1Data;
	logic [xLen-1:0]   rs2Data;
	logic [xLen-1:0]   opA;
	logic [xLen-1:0]   opB;
	logic [xLen-1:0]   aluResult;
	logic              takeBranch;
	logic [xLen-1:0]   pcPlus4;
	logic [xLen-1:0]   pcImm;
	logic [xLen-1:0]   writeData;

	assign instW = inst;

	assign opA = aluSrcPc ? pc : rs1Data;
	assign opB = aluSrcImm ? imm : rs2Data;

	assign dataAddr = aluResult;
	assign storeData = rs2Data; // memory takes the low lanes

	rvDecoder decoder_i (
		.rst(rst), .isnt(instW), .halt(halt),
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.regWrite(regWrite), .wbSel(wbSel), .branch(branch),
		.branchType(branchType), .jump(jump), .memRead(memRead),
		.memWrite(memWrite), .dataSize(dataSize), .dataUnsigned(dataUnsigned),
		.isEbreak(isEbreak)
	);

	rvImmGen immGen_i (.isnt(instW), .imm(imm));

	rvRegFile regFile_i (
		.clk(clk), .rst(rst),
		.rs1(instW.rView.rs1), .rs2(instW.rView.rs2), .rd(instW.rView.rd),
		.regWrite(regWrite), .writeData(writeData),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	rvAlu alu_i (
		.opA(opA), .opB(opB), .aluOp(aluOp), .branchType(branchType),
		.result(aluResult), .takeBranch(takeBranch)
	);

	rvPcUnit pcUnit_i (
		.clk(clk), .rst(rst), .imm(imm), .branch(branch),
		.takeBranch(takeBranch), .jump(jump), .isEbreak(isEbreak),
		.pc(pc), .pcPlus4(pcPlus4), .pcImm(pcImm), .halt(halt)
	);

	rvWriteback writeback_i (
		.wbSel(wbSel), .aluResult(aluResult), .readData(readData),
		.dataSize(dataSize), .dataUnsigned(dataUnsigned),
		.pcPlus4(pcPlus4), .pcImm(pcImm), .writeData(writeData)
	);

endmodule

// File: rtl/rvDecoder.sv
`timescale 1ns/100ps

module rvDecoder (
	input  logic                         rst,
	input  rvCorePkg::instWordT          isnt,
	input  logic                         halt,
	output logic [rvCorePkg::aluOpW-1:0] aluOp,
	output logic                         aluSrcImm,
	output logic                         aluSrcPc,
	output logic                         regWrite,
	output logic [rvCorePkg::wbSelW-1:0] wbSel,
	output logic                         branch,
	output logic [1:0]                   branchType,
	output logic                         jump,
	output logic                         memRead,
	output logic                         memWrite,
	output logic [rvCorePkg::sizeW-1:0]  dataSize,
	output logic                         dataUnsigned,
	output logic                         isEbreak
);
	import rvCorePkg::*;

	logic              blocked;
	logic              altOp;
	logic [aluOpW-1:0] arithOp;
	logic              regWriteRaw;
	logic              memReadRaw;
	logic              memWriteRaw;
	logic              ebreakRaw;
	logic [funct3W-1:0] f3;

	assign f3 = isnt.rView.funct3;
	assign blocked = rst | halt;

	// funct7[5] picks sub only for register ops, sra for both
	assign altOp = isnt.rView.funct7[5] & (isnt.rView.opcode == opReg || f3 == 3'b101);

	always_comb begin
		case (f3)
			3'b000: arithOp = altOp ? aluSub : aluAdd;
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = altOp ? aluSra : aluSrl;
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	end

	always_comb begin
		aluOp = aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		regWriteRaw = 1'b0;
		wbSel = wbAlu;
		branch = 1'b0;
		branchType = {f3[2], f3[0]}; // eq ne lt ge
		jump = 1'b0;
		memReadRaw = 1'b0;
		memWriteRaw = 1'b0;
		dataSize = sizeWord;
		dataUnsigned = 1'b0;
		ebreakRaw = 1'b0;
		case (isnt.rView.opcode)
			opLui: begin
				aluOp = aluPassB;
				aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opAuipc: begin
				aluSrcPc = 1'b1;
				aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
				wbSel = wbPcImm;
			end
			opJal: begin
				jump = 1'b1;
				regWriteRaw = 1'b1;
				wbSel = wbPcPlus4;
			end
			opBranch: begin
				aluOp = aluSub;
				branch = ~f3[1]; // bltu/bgeu not supported
			end
			opLoad: begin
				aluSrcImm = 1'b1;
				if (f3 != 3'b011 && f3[2:1] != 2'b11) begin
					memReadRaw = 1'b1;
					regWriteRaw = 1'b1;
					wbSel = wbMem;
					dataSize = f3[1:0];
					dataUnsigned = f3[2];
				end
			end
			opStore: begin
				aluSrcImm = 1'b1;
				if (f3 < 3'b011) begin
					memWriteRaw = 1'b1;
					dataSize = f3[1:0];
				end
			end
			opImm: begin
				aluOp = arithOp;
				aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opReg: begin
				aluOp = arithOp;
				regWriteRaw = 1'b1;
			end
			opSystem: begin
				ebreakRaw = (isnt.rView.funct7 == '0) && (isnt.rView.rs2 == 5'd1)
					&& (isnt.rView.rs1 == '0) && (f3 == '0) && (isnt.rView.rd == '0);
			end
			default: ; // no-op
		endcase
	end

	assign regWrite = regWriteRaw & ~blocked;
	assign memRead = memReadRaw & ~blocked;
	assign memWrite = memWriteRaw & ~blocked;
	assign isEbreak = ebreakRaw & ~blocked;

endmodule

// File: rtl/rvImmGen.sv
`timescale 1ns/100ps

module rvImmGen (
	input  rvCorePkg::instWordT         isnt,
	output logic [rvCorePkg::xLen-1:0]  imm
);
	import rvCorePkg::*;

	always_comb begin
		case (isnt.rView.opcode)
			opImm, opLoad: begin
				imm = {{20{isnt.rView.funct7[6]}}, isnt.rView.funct7, isnt.rView.rs2};
			end
			opStore: begin
				imm = {{20{isnt.sView.immHi[6]}}, isnt.sView.immHi, isnt.sView.immLo};
			end
			opBranch: begin
				imm = {{19{isnt.sView.immHi[6]}}, isnt.sView.immHi[6], isnt.sView.immLo[0],
					isnt.sView.immHi[5:0], isnt.sView.immLo[4:1], 1'b0};
			end
			opLui, opAuipc: begin
				imm = {isnt.rView.funct7, isnt.rView.rs2, isnt.rView.rs1, isnt.rView.funct3,
					12'b0};
			end
			opJal: begin
				// imm[19:12] sits in rs1/funct3, imm[11] in rs2[0]
				imm = {{11{isnt.rView.funct7[6]}}, isnt.rView.funct7[6], isnt.rView.rs1,
					isnt.rView.funct3, isnt.rView.rs2[0], isnt.rView.funct7[5:0],
					isnt.rView.rs2[4:1], 1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

// File: rtl/rvPcUnit.sv
`timescale 1ns/100ps

module rvPcUnit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [rvCorePkg::xLen-1:0]  imm,
	input  logic                        branch,
	input  logic                        takeBranch,
	input  logic                        jump,
	input  logic                        isEbreak,
	output logic [rvCorePkg::xLen-1:0]  pc,
	output logic [rvCorePkg::xLen-1:0]  pcPlus4,
	output logic [rvCorePkg::xLen-1:0]  pcImm,
	output logic                        halt
);
	import rvCorePkg::*;

	logic [xLen-1:0] pcNext;

	assign pcPlus4 = pc + 32'd4;
	assign pcImm = pc + imm; // branch/jal target, auipc value
	assign pcNext = (jump || (branch && takeBranch)) ? pcImm : pcPlus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halt <= 1'b0;
		end else if (!halt) begin
			if (isEbreak) begin
				halt <= 1'b1; // pc stays on the ebreak
			end else begin
				pc <= pcNext;
			end
		end
	end

endmodule

// File: rtl/rvRegFile.sv
`timescale 1ns/100ps

module rvRegFile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [rvCorePkg::regAddrW-1:0]  rs1,
	input  logic [rvCorePkg::regAddrW-1:0]  rs2,
	input  logic [rvCorePkg::regAddrW-1:0]  rd,
	input  logic                            regWrite,
	input  logic [rvCorePkg::xLen-1:0]      writeData,
	output logic [rvCorePkg::xLen-1:0]      rs1Data,
	output logic [rvCorePkg::xLen-1:0]      rs2Data
);
	import rvCorePkg::*;

	logic [xLen-1:0] regs [1:31]; // no storage for x0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && rd != '0) begin
			regs[rd] <= writeData;
		end
	end

	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/rvWriteback.sv
`timescale 1ns/100ps

module rvWriteback (
	input  logic [rvCorePkg::wbSelW-1:0] wbSel,
	input  logic [rvCorePkg::xLen-1:0]   aluResult,
	input  logic [rvCorePkg::xLen-1:0]   readData,
	input  logic [rvCorePkg::sizeW-1:0]  dataSize,
	input  logic                         dataUnsigned,
	input  logic [rvCorePkg::xLen-1:0]   pcPlus4,
	input  logic [rvCorePkg::xLen-1:0]   pcImm,
	output logic [rvCorePkg::xLen-1:0]   writeData
);
	import rvCorePkg::*;

	logic [xLen-1:0] loadVal;

	always_comb begin
		case (dataSize)
			sizeByte: loadVal = {{24{readData[7] & ~dataUnsigned}}, readData[7:0]};
			sizeHalf: loadVal = {{16{readData[15] & ~dataUnsigned}}, readData[15:0]};
			default:  loadVal = readData;
		endcase
	end

	always_comb begin
		case (wbSel)
			wbMem:     writeData = loadVal;
			wbPcPlus4: writeData = pcPlus4; // jal link
			wbPcImm:   writeData = pcImm;
			default:   writeData = aluResult;
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rvCoreTb \
	-Mdir obj_dir -f verilog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/VrvCoreTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

// File: verif/rvCoreAssertions.sv
`timescale 1ns/100ps

module rvCoreAssertions (
	input logic                       clk,
	input logic                       rst,
	input logic [rvCorePkg::xLen-1:0] pc,
	input logic                       memWrite,
	input logic                       memRead,
	input logic                       halt
);

	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc %h not word aligned", pc);

	memExclusive: assert property (@(posedge clk) disable iff (rst) !(memWrite && memRead))
		else $error("memWrite and memRead both high");

	// sticky until the next reset
	haltSticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
		else $error("halt dropped without reset");

	pcHold: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
		else $error("pc moved while halted");

endmodule

bind rvCoreTop rvCoreAssertions assertions_i (
	.clk(clk), .rst(rst), .pc(pc), .memWrite(memWrite), .memRead(memRead), .halt(halt)
);

// File: verif/rvCoreTb.sv
`timescale 1ns/100ps

module rvCoreTb;
	import rvCorePkg::*;

	localparam int progLen = 200;
	localparam int cycleLimit = progLen + 50; // program plus margin
	localparam logic [31:0] ebreakWord = 32'h0010_0073;

	logic             clk;
	logic             rst;
	logic [xLen-1:0]  inst;
	logic [xLen-1:0]  readData;
	logic [xLen-1:0]  pc;
	logic [xLen-1:0]  dataAddr;
	logic [xLen-1:0]  storeData;
	logic [sizeW-1:0] dataSize;
	logic             dataUnsigned;
	logic             memWrite;
	logic             memRead;
	logic             halt;

	integer           seed;
	logic [31:0]      imem [0:255];
	logic [7:0]       dmem [0:1023]; // DUT side
	logic [7:0]       mmem [0:1023]; // model side
	logic [xLen-1:0]  mregs [0:31];
	logic [xLen-1:0]  mpc;
	logic             mhalt;
	logic             expStore;
	logic             expLoad;
	logic [xLen-1:0]  expAddr;
	logic [xLen-1:0]  expData;
	logic [sizeW-1:0] expSize;
	logic             expUnsigned;
	int               cycles;
	int               haltCycles;

	rvCoreTop dut_i (
		.clk(clk), .rst(rst), .inst(inst), .readData(readData), .pc(pc),
		.dataAddr(dataAddr), .storeData(storeData), .dataSize(dataSize),
		.dataUnsigned(dataUnsigned), .memWrite(memWrite), .memRead(memRead), .halt(halt)
	);

	assign inst = imem[pc[9:2]];
	assign readData = {dmem[dataAddr[9:0] + 10'd3], dmem[dataAddr[9:0] + 10'd2],
		dmem[dataAddr[9:0] + 10'd1], dmem[dataAddr[9:0]]};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// store lanes land on the edge
	always @(posedge clk) begin
		if (memWrite) begin
			dmem[dataAddr[9:0]] <= storeData[7:0];
			if (dataSize != sizeByte) begin
				dmem[dataAddr[9:0] + 10'd1] <= storeData[15:8];
			end
			if (dataSize == sizeWord) begin
				dmem[dataAddr[9:0] + 10'd2] <= storeData[23:16];
				dmem[dataAddr[9:0] + 10'd3] <= storeData[31:24];
			end
		end
	end

	always @(negedge clk) begin
		if (rst) begin
			checkFlag("memWrite", memWrite, 1'b0);
			checkFlag("memRead", memRead, 1'b0);
		end
	end

	function automatic logic [31:0] randBelow(int unsigned n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic logic [11:0] alignOff(logic [9:0] a, logic [1:0] sz);
		case (sz)
			2'd0: return {2'b00, a};
			2'd1: return {2'b00, a[9:1], 1'b0};
			default: return {2'b00, a[9:2], 2'b00};
		endcase
	endfunction

	function automatic logic [xLen-1:0] aluModel(logic [2:0] f3, logic alt,
		logic [xLen-1:0] x, logic [xLen-1:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkPc(logic [xLen-1:0] got, logic [xLen-1:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR t=%0t pc: got %h expected %h", $time, got, exp));
		end
	endtask

	task automatic checkStore(logic [xLen-1:0] gotAddr, logic [xLen-1:0] wantAddr,
		logic [xLen-1:0] gotData, logic [xLen-1:0] wantData,
		logic [sizeW-1:0] gotSize, logic [sizeW-1:0] wantSize);
		if (gotAddr !== wantAddr) begin
			abortRun($sformatf("ERROR t=%0t dataAddr: got %h expected %h",
				$time, gotAddr, wantAddr));
		end else if (gotData !== wantData) begin
			abortRun($sformatf("ERROR t=%0t storeData: got %h expected %h",
				$time, gotData, wantData));
		end else if (gotSize !== wantSize) begin
			abortRun($sformatf("ERROR t=%0t dataSize: got %0d expected %0d",
				$time, gotSize, wantSize));
		end
	endtask

	task automatic checkLoad(logic [xLen-1:0] gotAddr, logic [xLen-1:0] wantAddr,
		logic [sizeW-1:0] gotSize, logic [sizeW-1:0] wantSize,
		logic gotUnsigned, logic wantUnsigned);
		if (gotAddr !== wantAddr) begin
			abortRun($sformatf("ERROR t=%0t dataAddr: got %h expected %h",
				$time, gotAddr, wantAddr));
		end else if (gotSize !== wantSize) begin
			abortRun($sformatf("ERROR t=%0t dataSize: got %0d expected %0d",
				$time, gotSize, wantSize));
		end else if (gotUnsigned !== wantUnsigned) begin
			abortRun($sformatf("ERROR t=%0t dataUnsigned: got %b expected %b",
				$time, gotUnsigned, wantUnsigned));
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic fillData();
		logic [7:0] b;
		for (int i = 0; i < 1024; i++) begin
			b = 8'(i * 97 + (i >> 7));
			dmem[i] = b;
			mmem[i] = b;
		end
	endtask

	task automatic buildProgram();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [31:0] r;
		logic [11:0] o;
		logic [12:0] off;
		logic [20:0] joff;
		int          skip;
		for (int i = 0; i < 256; i++) begin
			imem[i] = ebreakWord;
		end
		for (int i = 0; i < progLen; i++) begin
			rd = 5'(randBelow(8)); // small pool so values get reused
			rs1 = 5'(randBelow(8));
			rs2 = 5'(randBelow(8));
			f3 = 3'(randBelow(8));
			r = $random(seed);
			skip = 1 + int'(randBelow(4));
			if (i + skip > progLen) begin
				skip = progLen - i;
			end
			off = 13'(skip * 4);
			joff = 21'(skip * 4);
			case (int'(randBelow(12)))
				0, 1: begin
					imem[i] = {(((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00),
						rs2, rs1, f3, rd, opReg};
				end
				2, 3: begin
					if (f3 == 3'd1 || f3 == 3'd5) begin
						r[31:25] = {1'b0, r[30] & f3[2], 5'b0};
					end
					imem[i] = {r[31:20], rs1, f3, rd, opImm};
				end
				4: imem[i] = {r[31:12], rd, opLui};
				5: imem[i] = {r[31:12], rd, opAuipc};
				6, 7: begin
					if (f3[1]) begin
						f3 = 3'd2;
					end
					imem[i] = {alignOff(r[9:0], f3[1:0]), 5'd0, f3, rd, opLoad};
				end
				8, 9: begin
					f3 = 3'(randBelow(3));
					o = alignOff(r[9:0], f3[1:0]);
					imem[i] = {o[11:5], rs2, 5'd0, f3, o[4:0], opStore};
				end
				10: begin
					f3 = {f3[2], 1'b0, f3[0]}; // beq bne blt bge
					imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
				end
				default: begin
					imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, opJal};
				end
			endcase
		end
	endtask

	// one instruction of the reference ISA
	task automatic modelStep();
		logic [31:0]     w;
		logic [xLen-1:0] a;
		logic [xLen-1:0] b;
		logic [xLen-1:0] immI;
		logic [xLen-1:0] immS;
		logic [xLen-1:0] immB;
		logic [xLen-1:0] immJ;
		logic [xLen-1:0] res;
		logic [xLen-1:0] nextPc;
		logic [9:0]      ad;
		logic [2:0]      f3;
		logic            wr;
		logic            taken;
		w = imem[mpc[9:2]];
		f3 = w[14:12];
		a = mregs[w[19:15]];
		b = mregs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		res = '0;
		wr = 1'b0;
		taken = 1'b0;
		nextPc = mpc + 32'd4;
		expStore = 1'b0;
		expLoad = 1'b0;
		case (w[6:0])
			opLui: begin
				res = {w[31:12], 12'b0};
				wr = 1'b1;
			end
			opAuipc: begin
				res = mpc + {w[31:12], 12'b0};
				wr = 1'b1;
			end
			opJal: begin
				res = mpc + 32'd4;
				wr = 1'b1;
				nextPc = mpc + immJ;
			end
			opBranch: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					default: taken = ($signed(a) >= $signed(b));
				endcase
				if (taken) begin
					nextPc = mpc + immB;
				end
			end
			opLoad: begin
				expLoad = 1'b1;
				expAddr = a + immI;
				expSize = f3[1:0];
				expUnsigned = f3[2];
				ad = expAddr[9:0];
				res = {mmem[ad + 10'd3], mmem[ad + 10'd2], mmem[ad + 10'd1], mmem[ad]};
				case (f3)
					3'd0: res = {{24{res[7]}}, res[7:0]};
					3'd1: res = {{16{res[15]}}, res[15:0]};
					3'd4: res = {24'b0, res[7:0]};
					3'd5: res = {16'b0, res[15:0]};
					default: ;
				endcase
				wr = 1'b1;
			end
			opStore: begin
				expStore = 1'b1;
				expAddr = a + immS;
				expData = b;
				expSize = f3[1:0];
				ad = expAddr[9:0];
				mmem[ad] = b[7:0];
				if (f3 != 3'd0) begin
					mmem[ad + 10'd1] = b[15:8];
				end
				if (f3 == 3'd2) begin
					mmem[ad + 10'd2] = b[23:16];
					mmem[ad + 10'd3] = b[31:24];
				end
			end
			opImm: begin
				res = aluModel(f3, f3 == 3'd5 && w[30], a, immI);
				wr = 1'b1;
			end
			opReg: begin
				res = aluModel(f3, w[30], a, b);
				wr = 1'b1;
			end
			opSystem: begin
				mhalt = 1'b1; // only ebreak is generated
				nextPc = mpc;
			end
			default: ;
		endcase
		if (wr && w[11:7] != 5'd0) begin
			mregs[w[11:7]] = res;
		end
		mpc = nextPc;
	endtask

	initial begin
		seed = 32'h5202_788c;
		rst = 1'b1;
		cycles = 0;
		haltCycles = 0;
		mpc = '0;
		mhalt = 1'b0;
		expStore = 1'b0;
		expLoad = 1'b0;
		expAddr = '0;
		expData = '0;
		expSize = '0;
		expUnsigned = 1'b0;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		fillData();
		buildProgram();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		while (haltCycles < 5) begin
			@(negedge clk);
			cycles++;
			if (cycles > cycleLimit) begin
				abortRun($sformatf("timeout: core did not halt within %0d cycles", cycleLimit));
			end
			checkPc(pc, mpc);
			checkFlag("halt", halt, mhalt);
			if (mhalt) begin
				checkFlag("memWrite", memWrite, 1'b0);
				checkFlag("memRead", memRead, 1'b0);
				haltCycles++;
			end else begin
				modelStep();
				checkFlag("memWrite", memWrite, expStore);
				checkFlag("memRead", memRead, expLoad);
				if (expStore) begin
					checkStore(dataAddr, expAddr, storeData, expData, dataSize, expSize);
				end
				if (expLoad) begin
					checkLoad(dataAddr, expAddr, dataSize, expSize, dataUnsigned, expUnsigned);
				end
			end
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// File: verilog.f
rtl/rvCorePkg.sv
rtl/rvDecoder.sv
rtl/rvImmGen.sv
rtl/rvRegFile.sv
rtl/rvAlu.sv
rtl/rvPcUnit.sv
rtl/rvWriteback.sv
rtl/rvCoreTop.sv
verif/rvCoreAssertions.sv
verif/rvCoreTb.sv
